// ==== build.f ====
+incdir+test
hdl/rv32i_pkg.sv
hdl/ctrl_rom.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv32i_pipe.sv
test/tb_rv32i_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the pipeline testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timescale 1ns/1ps -f build.f \
  --top-module tb_rv32i_pipe -o tb_rv32i_pipe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_rv32i_pipe > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  exit 1
fi
if ! grep -q "test passed" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// ==== test/rv32i_model.svh ====
`ifndef RV32I_MODEL_SVH
`define RV32I_MODEL_SVH

logic [31:0] arch_regs [32];
logic [31:0] arch_mem [dmem_words];

// Expected records, oldest first, in issue order.
logic [4:0]  exp_retire_rd [$];
logic [31:0] exp_retire_data [$];
logic        exp_branch_taken [$];
logic [31:0] exp_branch_target [$];

task automatic clear_arch_state();
  for (int i = 0; i < 32; i++) begin
    arch_regs[i] = 32'd0;
  end
  for (int i = 0; i < dmem_words; i++) begin
    arch_mem[i] = 32'd0;
  end
endtask

// Integer ALU by funct3; alt selects sub and the arithmetic right shift.
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = {31'd0, $signed(a) < $signed(b)};
    3'd3: r = {31'd0, a < b};
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt)
        r = $signed(a) >>> b[4:0];
      else
        r = a >> b[4:0];
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic logic branch_outcome(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

task automatic execute_instr(input logic [6:0] opc, input logic [2:0] f3, input logic alt,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm,
                             input logic [31:0] pc);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] value;
  logic [31:0] target;
  logic        writes;
  logic        flow;
  logic        taken;
  a = arch_regs[rs1];
  b = arch_regs[rs2];
  addr = a + imm;
  value = 32'd0;
  target = 32'd0;
  writes = 1'b1;
  flow = 1'b0;
  taken = 1'b1;
  case (opc)
    op_lui: value = imm;
    op_auipc: value = pc + imm;
    op_jal: begin
      value = pc + 32'd4;
      flow = 1'b1;
      target = pc + imm;
    end
    op_jalr: begin
      value = pc + 32'd4;
      flow = 1'b1;
      target = {addr[31:1], 1'b0};
    end
    op_br: begin
      writes = 1'b0;
      flow = 1'b1;
      taken = branch_outcome(f3, a, b);
      target = pc + imm;
    end
    op_load: value = arch_mem[addr[9:2]];
    op_store: begin
      writes = 1'b0;
      arch_mem[addr[9:2]] = b;
    end
    op_imm: value = alu_result(f3, alt, a, imm);
    op_reg: value = alu_result(f3, alt, a, b);
    default: writes = 1'b0;
  endcase
  // A write to x0 still retires with its computed value.
  if (writes) begin
    exp_retire_rd.push_back(rd);
    exp_retire_data.push_back(value);
    if (rd != 5'd0) begin
      arch_regs[rd] = value;
    end
  end
  if (flow) begin
    exp_branch_taken.push_back(taken);
    exp_branch_target.push_back(target);
  end
endtask

`endif

// ==== test/tb_rv32i_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_pipe
  import rv32i_pkg::*;
();

  localparam int instr_count = 400;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        branch_valid;
  logic        branch_taken;
  logic [31:0] branch_target;

  integer      seed;
  int          error_count;
  logic [31:0] next_pc;
  // Destination of a load issued last; the next instruction must not read it.
  logic [4:0]  load_guard;

  `include "rv32i_model.svh"

  rv32i_pipe rv32i_pipe_i (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .instr_pc      (instr_pc),
    .retire_valid  (retire_valid),
    .retire_rd     (retire_rd),
    .retire_data   (retire_data),
    .branch_valid  (branch_valid),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [4:0] pick_src();
    logic [4:0] r;
    r = 5'(rand_below(8));
    if (load_guard != 5'd0 && r == load_guard) begin
      r = (r + 5'd1) & 5'd7;
    end
    return r;
  endfunction

  // x7 holds the memory base, so random results never land there.
  function automatic logic [4:0] pick_dest();
    return 5'(rand_below(7));
  endfunction

  function automatic logic [31:0] encode_instr(input logic [6:0] opc, input logic [2:0] f3,
                                               input logic [6:0] f7, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [31:0] imm);
    case (opc)
      op_lui, op_auipc: return {imm[31:12], rd, opc};
      op_jal: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
      op_br: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
      op_store: return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
      op_reg: return {f7, rs2, rs1, f3, rd, opc};
      default: return {imm[11:0], rs1, f3, rd, opc};
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic drive_instr(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                             input logic alt, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm);
    execute_instr(opc, f3, alt, rd, rs1, rs2, imm, next_pc);
    instr = encode_instr(opc, f3, f7, rd, rs1, rs2, imm);
    instr_pc = next_pc;
    instr_valid = 1'b1;
    next_pc = next_pc + 32'd4;
    load_guard = (opc == op_load) ? rd : 5'd0;
  endtask

  task automatic issue_random();
    int          kind;
    int          pick;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    kind = rand_below(20);
    f3 = 3'd0;
    f7 = 7'd0;
    alt = 1'b0;
    rd = pick_dest();
    rs1 = pick_src();
    rs2 = pick_src();
    imm = 32'd0;
    if (kind < 6) begin
      opc = op_imm;
      f3 = 3'(rand_below(8));
      if (f3 == 3'd1 || f3 == 3'd5) begin
        // Shifts carry funct7 in the upper immediate bits.
        alt = (f3 == 3'd5) && (rand_below(2) == 1);
        imm = {20'd0, alt ? 7'h20 : 7'h00, 5'(rand_below(32))};
      end else begin
        imm = 32'(rand_below(4096) - 2048);
      end
    end else if (kind < 10) begin
      opc = op_reg;
      f3 = 3'(rand_below(8));
      alt = (f3 == 3'd0 || f3 == 3'd5) && (rand_below(2) == 1);
      f7 = alt ? 7'h20 : 7'h00;
    end else if (kind < 12) begin
      opc = (kind == 10) ? op_lui : op_auipc;
      imm = {20'(rand_below(1 << 20)), 12'h000};
    end else if (kind == 12) begin
      opc = op_jal;
      imm = 32'((rand_below(1 << 20) - (1 << 19)) * 2);
    end else if (kind == 13) begin
      opc = op_jalr;
      imm = 32'(rand_below(4096) - 2048);
    end else if (kind < 16) begin
      opc = op_br;
      pick = rand_below(6);
      f3 = (pick < 2) ? 3'(pick) : 3'(pick + 2);
      imm = 32'((rand_below(4096) - 2048) * 2);
    end else begin
      // Loads and stores hit one of 16 words above the base in x7.
      opc = (kind < 18) ? op_load : op_store;
      f3 = 3'd2;
      rs1 = 5'd7;
      imm = 32'(rand_below(16) * 4);
    end
    drive_instr(opc, f3, f7, alt, rd, rs1, rs2, imm);
  endtask

  always @(negedge clk) begin
    if (!reset && retire_valid) begin
      if (exp_retire_rd.size() == 0) begin
        $display("ERROR at %0t: retire pulse with no instruction left to retire", $time);
        error_count++;
      end else begin
        check_value("retire_rd", 32'(retire_rd), 32'(exp_retire_rd.pop_front()));
        check_value("retire_data", retire_data, exp_retire_data.pop_front());
      end
    end
    if (!reset && branch_valid) begin
      if (exp_branch_taken.size() == 0) begin
        $display("ERROR at %0t: branch pulse with no branch or jump outstanding", $time);
        error_count++;
      end else begin
        check_value("branch_taken", 32'(branch_taken), 32'(exp_branch_taken.pop_front()));
        check_value("branch_target", branch_target, exp_branch_target.pop_front());
      end
    end
  end

  initial begin
    int issued;
    int cycles;
    seed = 15;
    error_count = 0;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = 32'd0;
    instr_pc = 32'd0;
    next_pc = 32'h0000_1000;
    load_guard = 5'd0;
    clear_arch_state();
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (4) begin
      @(negedge clk);
      check_value("retire_valid while idle", 32'(retire_valid), 32'd0);
      check_value("branch_valid while idle", 32'(branch_valid), 32'd0);
    end

    @(posedge clk);
    #1;
    drive_instr(op_lui, 3'd0, 7'd0, 1'b0, 5'd7, 5'd0, 5'd0, 32'h0001_2000);
    issued = 1;
    while (issued < instr_count) begin
      @(posedge clk);
      #1;
      if (rand_below(8) == 0) begin
        instr_valid = 1'b0;
      end else begin
        issue_random();
        issued++;
      end
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;

    cycles = 0;
    while ((exp_retire_rd.size() != 0 || exp_branch_taken.size() != 0) && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_retire_rd.size() != 0 || exp_branch_taken.size() != 0) begin
      $display("ERROR: %0d retire and %0d branch records did not arrive within 20 cycles",
               exp_retire_rd.size(), exp_branch_taken.size());
      error_count++;
    end
    // A few quiet cycles catch any extra pulses.
    repeat (4) @(posedge clk);

    $display("%0d errors after %0d instructions", error_count, issued);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/rv32i_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_pipe
  import rv32i_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] instr_pc,
  output logic            retire_valid,
  output logic [4:0]      retire_rd,
  output logic [xlen-1:0] retire_data,
  output logic            branch_valid,
  output logic            branch_taken,
  output logic [xlen-1:0] branch_target
);

  logic [4:0]      rs1_idx;
  logic [4:0]      rs2_idx;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  logic            id_valid;
  ctrl_word_struct id_ctrl;
  logic [xlen-1:0] id_pc;
  logic [4:0]      id_rs1;
  logic [4:0]      id_rs2;
  logic [xlen-1:0] id_rs1_val;
  logic [xlen-1:0] id_rs2_val;
  logic [4:0]      id_rd;
  logic [xlen-1:0] id_i_imm;
  logic [xlen-1:0] id_s_imm;
  logic [xlen-1:0] id_b_imm;
  logic [xlen-1:0] id_u_imm;
  logic [xlen-1:0] id_j_imm;

  logic            ex_valid;
  ctrl_word_struct ex_ctrl;
  logic [xlen-1:0] ex_pc;
  logic [4:0]      ex_rd;
  logic [xlen-1:0] ex_alu;
  logic            ex_br_en;
  logic [xlen-1:0] ex_store_data;
  logic [xlen-1:0] ex_u_imm;

  logic            fwd_valid;
  logic [4:0]      fwd_rd;
  logic [xlen-1:0] fwd_data;
  logic            wb_valid;
  logic [4:0]      wb_rd;
  logic [xlen-1:0] wb_data;

  decode_stage decode_stage_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .id_valid    (id_valid),
    .id_ctrl     (id_ctrl),
    .id_pc       (id_pc),
    .id_rs1      (id_rs1),
    .id_rs2      (id_rs2),
    .id_rs1_val  (id_rs1_val),
    .id_rs2_val  (id_rs2_val),
    .id_rd       (id_rd),
    .id_i_imm    (id_i_imm),
    .id_s_imm    (id_s_imm),
    .id_b_imm    (id_b_imm),
    .id_u_imm    (id_u_imm),
    .id_j_imm    (id_j_imm)
  );

  regfile regfile_i (
    .clk     (clk),
    .reset   (reset),
    .load    (wb_valid),
    .rd      (wb_rd),
    .wdata   (wb_data),
    .rs1     (rs1_idx),
    .rs2     (rs2_idx),
    .rs1_out (rs1_data),
    .rs2_out (rs2_data)
  );

  execute_stage execute_stage_i (
    .clk           (clk),
    .reset         (reset),
    .id_valid      (id_valid),
    .id_ctrl       (id_ctrl),
    .id_pc         (id_pc),
    .id_rs1        (id_rs1),
    .id_rs2        (id_rs2),
    .id_rs1_val    (id_rs1_val),
    .id_rs2_val    (id_rs2_val),
    .id_rd         (id_rd),
    .id_i_imm      (id_i_imm),
    .id_s_imm      (id_s_imm),
    .id_b_imm      (id_b_imm),
    .id_u_imm      (id_u_imm),
    .id_j_imm      (id_j_imm),
    .fwd_valid     (fwd_valid),
    .fwd_rd        (fwd_rd),
    .fwd_data      (fwd_data),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .ex_valid      (ex_valid),
    .ex_ctrl       (ex_ctrl),
    .ex_pc         (ex_pc),
    .ex_rd         (ex_rd),
    .ex_alu        (ex_alu),
    .ex_br_en      (ex_br_en),
    .ex_store_data (ex_store_data),
    .ex_u_imm      (ex_u_imm),
    .branch_valid  (branch_valid),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  memory_stage memory_stage_i (
    .clk           (clk),
    .reset         (reset),
    .ex_valid      (ex_valid),
    .ex_ctrl       (ex_ctrl),
    .ex_pc         (ex_pc),
    .ex_rd         (ex_rd),
    .ex_alu        (ex_alu),
    .ex_br_en      (ex_br_en),
    .ex_store_data (ex_store_data),
    .ex_u_imm      (ex_u_imm),
    .fwd_valid     (fwd_valid),
    .fwd_rd        (fwd_rd),
    .fwd_data      (fwd_data),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data)
  );

  assign retire_valid = wb_valid;
  assign retire_rd = wb_rd;
  assign retire_data = wb_data;

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage
  import rv32i_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            ex_valid,
  input  ctrl_word_struct ex_ctrl,
  input  logic [xlen-1:0] ex_pc,
  input  logic [4:0]      ex_rd,
  input  logic [xlen-1:0] ex_alu,
  input  logic            ex_br_en,
  input  logic [xlen-1:0] ex_store_data,
  input  logic [xlen-1:0] ex_u_imm,
  output logic            fwd_valid,
  output logic [4:0]      fwd_rd,
  output logic [xlen-1:0] fwd_data,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [xlen-1:0] wb_data
);

  logic [xlen-1:0]    dmem [dmem_words];
  logic [dmem_aw-1:0] addr;
  logic [xlen-1:0]    load_data;
  logic [xlen-1:0]    result;
  logic               retire;

  assign addr = ex_alu[dmem_aw+1:2];
  assign load_data = ex_ctrl.dcache_read ? dmem[addr] : '0;
  assign retire = ex_valid && ex_ctrl.regfile_ld;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_valid && ex_ctrl.dcache_write) begin
      dmem[addr] <= ex_store_data;
    end
  end

  always_comb begin
    unique case (ex_ctrl.regfilemux_sel)
      regfilemux_br_en:    result = {{(xlen-1){1'b0}}, ex_br_en};
      regfilemux_u_imm:    result = ex_u_imm;
      regfilemux_lw:       result = load_data;
      regfilemux_pc_plus4: result = ex_pc + 32'd4;
      default:             result = ex_alu;
    endcase
  end

  // Loads are excluded here; the stimulus keeps their consumers one slot away.
  assign fwd_valid = retire && !ex_ctrl.dcache_read && ex_rd != 5'd0;
  assign fwd_rd = ex_rd;
  assign fwd_data = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= retire;
      if (retire) begin
        wb_rd   <= ex_rd;
        wb_data <= result;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import rv32i_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            id_valid,
  input  ctrl_word_struct id_ctrl,
  input  logic [xlen-1:0] id_pc,
  input  logic [4:0]      id_rs1,
  input  logic [4:0]      id_rs2,
  input  logic [xlen-1:0] id_rs1_val,
  input  logic [xlen-1:0] id_rs2_val,
  input  logic [4:0]      id_rd,
  input  logic [xlen-1:0] id_i_imm,
  input  logic [xlen-1:0] id_s_imm,
  input  logic [xlen-1:0] id_b_imm,
  input  logic [xlen-1:0] id_u_imm,
  input  logic [xlen-1:0] id_j_imm,
  input  logic            fwd_valid,
  input  logic [4:0]      fwd_rd,
  input  logic [xlen-1:0] fwd_data,
  input  logic            wb_valid,
  input  logic [4:0]      wb_rd,
  input  logic [xlen-1:0] wb_data,
  output logic            ex_valid,
  output ctrl_word_struct ex_ctrl,
  output logic [xlen-1:0] ex_pc,
  output logic [4:0]      ex_rd,
  output logic [xlen-1:0] ex_alu,
  output logic            ex_br_en,
  output logic [xlen-1:0] ex_store_data,
  output logic [xlen-1:0] ex_u_imm,
  output logic            branch_valid,
  output logic            branch_taken,
  output logic [xlen-1:0] branch_target
);

  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] cmp_b;
  logic [xlen-1:0] alu_res;
  logic            br_en;
  logic            is_jalr;
  logic            is_flow;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            load_pending;

  // The memory stage holds the younger result, so it wins over writeback.
  always_comb begin
    if (fwd_valid && fwd_rd == id_rs1) rs1_val = fwd_data;
    else if (wb_valid && wb_rd != 5'd0 && wb_rd == id_rs1) rs1_val = wb_data;
    else rs1_val = id_rs1_val;
    if (fwd_valid && fwd_rd == id_rs2) rs2_val = fwd_data;
    else if (wb_valid && wb_rd != 5'd0 && wb_rd == id_rs2) rs2_val = wb_data;
    else rs2_val = id_rs2_val;
  end

  assign alu_a = (id_ctrl.alumux1_sel == alumux1_pc_out) ? id_pc : rs1_val;
  assign cmp_b = (id_ctrl.cmpmux_sel == cmpmux_i_imm) ? id_i_imm : rs2_val;

  always_comb begin
    unique case (id_ctrl.alumux2_sel)
      alumux2_u_imm:   alu_b = id_u_imm;
      alumux2_b_imm:   alu_b = id_b_imm;
      alumux2_s_imm:   alu_b = id_s_imm;
      alumux2_j_imm:   alu_b = id_j_imm;
      alumux2_rs2_out: alu_b = rs2_val;
      default:         alu_b = id_i_imm;
    endcase
  end

  always_comb begin
    unique case (id_ctrl.aluop)
      alu_sll: alu_res = alu_a << alu_b[4:0];
      alu_sra: alu_res = $unsigned($signed(alu_a) >>> alu_b[4:0]);
      alu_sub: alu_res = alu_a - alu_b;
      alu_xor: alu_res = alu_a ^ alu_b;
      alu_srl: alu_res = alu_a >> alu_b[4:0];
      alu_or:  alu_res = alu_a | alu_b;
      alu_and: alu_res = alu_a & alu_b;
      default: alu_res = alu_a + alu_b;
    endcase
  end

  always_comb begin
    unique case (id_ctrl.cmpop)
      beq:     br_en = (rs1_val == cmp_b);
      bne:     br_en = (rs1_val != cmp_b);
      blt:     br_en = ($signed(rs1_val) < $signed(cmp_b));
      bge:     br_en = ($signed(rs1_val) >= $signed(cmp_b));
      bltu:    br_en = (rs1_val < cmp_b);
      bgeu:    br_en = (rs1_val >= cmp_b);
      default: br_en = 1'b0;
    endcase
  end

  assign is_jalr = id_ctrl.is_jump && id_ctrl.alumux1_sel == alumux1_rs1_out;
  assign is_flow = id_valid && (id_ctrl.is_branch || id_ctrl.is_jump);

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid      <= 1'b0;
      ex_ctrl       <= ctrl_defaults();
      branch_valid  <= 1'b0;
      branch_taken  <= 1'b0;
      branch_target <= '0;
    end else begin
      ex_valid     <= id_valid;
      ex_ctrl      <= id_valid ? id_ctrl : ctrl_defaults();
      branch_valid <= is_flow;
      if (is_flow) begin
        branch_taken  <= id_ctrl.is_jump || br_en;
        branch_target <= is_jalr ? {alu_res[xlen-1:1], 1'b0} : alu_res;
      end
    end
  end

  always_ff @(posedge clk) begin
    ex_pc         <= id_pc;
    ex_rd         <= id_rd;
    ex_alu        <= alu_res;
    ex_br_en      <= br_en;
    ex_store_data <= rs2_val;
    ex_u_imm      <= id_u_imm;
  end

  // LUI, AUIPC and JAL ignore rs1; only OP, branches and stores read rs2.
  assign uses_rs1 = id_valid && (id_ctrl.is_branch ||
                    (id_ctrl.alumux1_sel == alumux1_rs1_out &&
                     (id_ctrl.regfile_ld || id_ctrl.dcache_write) &&
                     id_ctrl.regfilemux_sel != regfilemux_u_imm));
  assign uses_rs2 = id_valid && (id_ctrl.alumux2_sel == alumux2_rs2_out ||
                    id_ctrl.is_branch || id_ctrl.dcache_write);
  assign load_pending = ex_valid && ex_ctrl.dcache_read && ex_rd != 5'd0;

  // A load in the memory stage is not forwarded, so the next instruction must not read it.
  assert property (@(posedge clk) disable iff (reset)
    load_pending && uses_rs1 |-> id_rs1 != ex_rd)
    else $error("execute_stage: rs1 reads a load result one cycle too early");

  assert property (@(posedge clk) disable iff (reset)
    load_pending && uses_rs2 |-> id_rs2 != ex_rd)
    else $error("execute_stage: rs2 reads a load result one cycle too early");

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import rv32i_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  logic [31:0]     instr,
  input  logic [xlen-1:0] instr_pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic [4:0]      rs1_idx,
  output logic [4:0]      rs2_idx,
  output logic            id_valid,
  output ctrl_word_struct id_ctrl,
  output logic [xlen-1:0] id_pc,
  output logic [4:0]      id_rs1,
  output logic [4:0]      id_rs2,
  output logic [xlen-1:0] id_rs1_val,
  output logic [xlen-1:0] id_rs2_val,
  output logic [4:0]      id_rd,
  output logic [xlen-1:0] id_i_imm,
  output logic [xlen-1:0] id_s_imm,
  output logic [xlen-1:0] id_b_imm,
  output logic [xlen-1:0] id_u_imm,
  output logic [xlen-1:0] id_j_imm
);

  ctrl_word_struct rom_word;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] s_imm;
  logic [xlen-1:0] b_imm;
  logic [xlen-1:0] u_imm;
  logic [xlen-1:0] j_imm;

  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  assign i_imm = {{21{instr[31]}}, instr[30:20]};
  assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'h000};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  ctrl_rom ctrl_rom_i (
    .opcode    (rv32i_opcode'(instr[6:0])),
    .funct3    (instr[14:12]),
    .funct7    (instr[31:25]),
    .ctrl_word (rom_word)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_ctrl  <= ctrl_defaults();
    end else begin
      id_valid <= instr_valid;
      id_ctrl  <= instr_valid ? rom_word : ctrl_defaults();
    end
  end

  always_ff @(posedge clk) begin
    id_pc      <= instr_pc;
    id_rs1     <= rs1_idx;
    id_rs2     <= rs2_idx;
    id_rs1_val <= rs1_data;
    id_rs2_val <= rs2_data;
    id_rd      <= instr[11:7];
    id_i_imm   <= i_imm;
    id_s_imm   <= s_imm;
    id_b_imm   <= b_imm;
    id_u_imm   <= u_imm;
    id_j_imm   <= j_imm;
  end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
  import rv32i_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] wdata,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  output logic [xlen-1:0] rs1_out,
  output logic [xlen-1:0] rs2_out
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (load && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // A write in flight is visible to a read in the same cycle.
  always_comb begin
    if (rs1 == 5'd0) rs1_out = '0;
    else if (load && rd == rs1) rs1_out = wdata;
    else rs1_out = regs[rs1];
    if (rs2 == 5'd0) rs2_out = '0;
    else if (load && rd == rs2) rs2_out = wdata;
    else rs2_out = regs[rs2];
  end

endmodule

`default_nettype wire

// ==== hdl/ctrl_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_rom
  import rv32i_pkg::*;
(
  input  rv32i_opcode     opcode,
  input  logic [2:0]      funct3,
  input  logic [6:0]      funct7,
  output ctrl_word_struct ctrl_word
);

  always_comb begin
    ctrl_word = ctrl_defaults();
    unique case (opcode)
      op_lui: begin
        ctrl_word.regfile_ld = 1'b1;
        ctrl_word.regfilemux_sel = regfilemux_u_imm;
      end
      op_auipc: begin
        ctrl_word.regfile_ld = 1'b1;
        ctrl_word.alumux1_sel = alumux1_pc_out;
        ctrl_word.alumux2_sel = alumux2_u_imm;
      end
      op_jal: begin
        ctrl_word.regfile_ld = 1'b1;
        ctrl_word.regfilemux_sel = regfilemux_pc_plus4;
        ctrl_word.alumux1_sel = alumux1_pc_out;
        ctrl_word.alumux2_sel = alumux2_j_imm;
        ctrl_word.is_jump = 1'b1;
      end
      op_jalr: begin
        ctrl_word.regfile_ld = 1'b1;
        ctrl_word.regfilemux_sel = regfilemux_pc_plus4;
        ctrl_word.is_jump = 1'b1;
      end
      op_br: begin
        ctrl_word.alumux1_sel = alumux1_pc_out;
        ctrl_word.alumux2_sel = alumux2_b_imm;
        ctrl_word.cmpop = branch_funct3_t'(funct3);
        ctrl_word.is_branch = 1'b1;
      end
      op_load: begin
        ctrl_word.regfile_ld = 1'b1;
        ctrl_word.regfilemux_sel = regfilemux_lw;
        ctrl_word.dcache_read = 1'b1;
      end
      op_store: begin
        ctrl_word.alumux2_sel = alumux2_s_imm;
        ctrl_word.dcache_write = 1'b1;
      end
      op_imm, op_reg: begin
        ctrl_word.regfile_ld = 1'b1;
        ctrl_word.aluop = alu_ops'(funct3);
        if (opcode == op_reg) begin
          ctrl_word.alumux2_sel = alumux2_rs2_out;
        end else begin
          ctrl_word.cmpmux_sel = cmpmux_i_imm;
        end
        unique case (funct3)
          3'b000: begin
            // Only the register form has a subtract.
            if (opcode == op_reg && funct7[5]) begin
              ctrl_word.aluop = alu_sub;
            end
          end
          3'b010: begin
            ctrl_word.cmpop = blt;
            ctrl_word.regfilemux_sel = regfilemux_br_en;
          end
          3'b011: begin
            ctrl_word.cmpop = bltu;
            ctrl_word.regfilemux_sel = regfilemux_br_en;
          end
          3'b101: begin
            ctrl_word.aluop = funct7[5] ? alu_sra : alu_srl;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

  localparam int xlen = 32;
  localparam int dmem_words = 256;
  // Word index width; addresses use bits dmem_aw+1 down to 2.
  localparam int dmem_aw = $clog2(dmem_words);

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011,
    op_csr   = 7'b1110011
  } rv32i_opcode;

  // Encodings follow funct3 so most ALU ops decode by a plain cast.
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_ops;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  typedef enum logic {
    alumux1_rs1_out,
    alumux1_pc_out
  } alumux1_sel_t;

  typedef enum logic [2:0] {
    alumux2_i_imm,
    alumux2_u_imm,
    alumux2_b_imm,
    alumux2_s_imm,
    alumux2_j_imm,
    alumux2_rs2_out
  } alumux2_sel_t;

  typedef enum logic {
    cmpmux_rs2_out,
    cmpmux_i_imm
  } cmpmux_sel_t;

  // Five sources, so this select needs three bits.
  typedef enum logic [2:0] {
    regfilemux_alu_out,
    regfilemux_br_en,
    regfilemux_u_imm,
    regfilemux_lw,
    regfilemux_pc_plus4
  } regfilemux_sel_t;

  typedef struct packed {
    logic            regfile_ld;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
    regfilemux_sel_t regfilemux_sel;
    logic            dcache_read;
    logic            dcache_write;
    alu_ops          aluop;
    branch_funct3_t  cmpop;
    logic            is_branch;
    logic            is_jump;
  } ctrl_word_struct;

  // Control word of a no-op; also what a bubble carries down the pipe.
  function automatic ctrl_word_struct ctrl_defaults();
    ctrl_word_struct cw;
    cw.regfile_ld     = 1'b0;
    cw.alumux1_sel    = alumux1_rs1_out;
    cw.alumux2_sel    = alumux2_i_imm;
    cw.cmpmux_sel     = cmpmux_rs2_out;
    cw.regfilemux_sel = regfilemux_alu_out;
    cw.dcache_read    = 1'b0;
    cw.dcache_write   = 1'b0;
    cw.aluop          = alu_add;
    cw.cmpop          = beq;
    cw.is_branch      = 1'b0;
    cw.is_jump        = 1'b0;
    return cw;
  endfunction

endpackage

`default_nettype wire
